// File: project.f
+incdir+hdl
hdl/soc_pkg.sv
hdl/periph_if.sv
hdl/bus_router.sv
hdl/pwm_ctrl.sv
hdl/soc_periph_top.sv
sim/tb_soc_periph.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_soc_periph \
   -f project.f \
   -o Vtb_soc_periph

# The testbench prints its result line on stdout
if ./obj_dir/Vtb_soc_periph | tee /dev/stderr | grep -x "No errors" > /dev/null; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi

// File: sim/tb_soc_periph.sv
`include "soc_cfg.svh"

module tb_soc_periph;
   import soc_pkg::*;

   localparam int RESET_CYCLES = 16;
   localparam int NUM_ENTRIES  = 20;
   localparam int MEM_WORDS    = 2048;

   // PWM setup written by the last table entries
   localparam int PWM_P          = 9;
   localparam int PWM_D0         = 4;
   localparam int PWM_D1         = 12;
   localparam int WINDOW         = 4 * (PWM_P + 1);
   localparam int PWM_CYCLES     = 5 * WINDOW + 20;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ENTRIES * 10 + PWM_CYCLES;

   typedef struct packed {
      logic  write;
      addr_t addr;
      data_t wdata;
      data_t exp_data;
   } entry_t;

   logic  clk;
   logic  resetn;
   logic  req_valid_i;
   logic  req_ready_o;
   addr_t req_addr_i;
   data_t req_wdata_i;
   logic  req_write_i;
   logic  rsp_valid_o;
   data_t rsp_data_o;
   logic  iomem_valid_o;
   logic  iomem_ready_i;
   strb_t iomem_wstrb_o;
   addr_t iomem_addr_o;
   data_t iomem_wdata_o;
   data_t iomem_rdata_i;
   logic  pwm0_o;
   logic  pwm1_o;

   data_t mem [MEM_WORDS];

   // write, address, write data, expected read data
   entry_t stim_table [NUM_ENTRIES] = '{
      '{1'b1, `SOC_RAM_BASE + 32'h0,    32'h1122_3344, 32'h0},
      '{1'b1, `SOC_RAM_BASE + 32'h4,    32'hA5A5_5A5A, 32'h0},
      '{1'b1, `SOC_RAM_BASE + 32'hFFFC, 32'hDEAD_BEEF, 32'h0},
      '{1'b0, `SOC_RAM_BASE + 32'h0,    32'h0,         32'h1122_3344},
      '{1'b0, `SOC_RAM_BASE + 32'h4,    32'h0,         32'hA5A5_5A5A},
      '{1'b0, `SOC_RAM_BASE + 32'hFFFC, 32'h0,         32'hDEAD_BEEF},
      '{1'b1, `SOC_TIMER_BASE + 32'h8,  32'h0000_1000, 32'h0},
      '{1'b0, `SOC_TIMER_BASE + 32'h8,  32'h0,         32'h0000_1000},
      '{1'b1, 32'h5000_0000,            32'hFFFF_FFFF, 32'h0},
      '{1'b0, 32'h5000_0000,            32'h0,         32'h0},
      '{1'b1, `SOC_PWM_BASE + `PWM_REG_PERIOD, 32'hDEAD_0009, 32'h0},
      '{1'b1, `SOC_PWM_BASE + `PWM_REG_DUTY0,  32'hBEEF_0004, 32'h0},
      '{1'b1, `SOC_PWM_BASE + `PWM_REG_DUTY1,  32'h1234_000C, 32'h0},
      '{1'b0, `SOC_PWM_BASE + `PWM_REG_PERIOD, 32'h0,         32'h0000_0009},
      '{1'b0, `SOC_PWM_BASE + `PWM_REG_DUTY0,  32'h0,         32'h0000_0004},
      '{1'b0, `SOC_PWM_BASE + `PWM_REG_DUTY1,  32'h0,         32'h0000_000C},
      '{1'b0, `SOC_PWM_BASE + 32'h10,          32'h0,         32'h0},
      '{1'b0, `SOC_RAM_BASE + 32'h4,           32'h0,         32'hA5A5_5A5A},
      '{1'b1, `SOC_PWM_BASE + `PWM_REG_CTRL,   32'h0000_0003, 32'h0},
      '{1'b0, `SOC_PWM_BASE + `PWM_REG_CTRL,   32'h0,         32'h0000_0003}
   };

   soc_periph_top UUT (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // RAM and timer share the array with bit 30 as bank select
   function automatic int mem_index(input addr_t addr);
      return int'({addr[30], addr[11:2]});
   endfunction

   function automatic logic is_external(input addr_t addr);
      return ((addr & ~`SOC_RAM_MASK) == `SOC_RAM_BASE) ||
             ((addr & ~`SOC_TIMER_MASK) == `SOC_TIMER_BASE);
   endfunction

   function automatic int min_int(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   assign iomem_rdata_i = mem[mem_index(iomem_addr_o)];

   task automatic stop_run();
      $display("Errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_mismatch(input string sig, input data_t got, input data_t exp);
      $display("mismatch %s: got 0x%h, expected 0x%h", sig, got, exp);
      stop_run();
   endtask

   task automatic report_failure(input string what);
      $display("%s", what);
      stop_run();
   endtask

   // External memory with a random ready delay
   initial begin : memory_model
      int   wait_cnt;
      logic ready_next;
      void'($urandom(32'h3afb_a55c));
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = (data_t'(i) * 32'h9E37_79B9) ^ 32'h5A5A_0000;
      end
      wait_cnt = -1;
      ready_next = 1'b0;
      iomem_ready_i = 1'b0;
      forever begin
         @(posedge clk);
         if (iomem_valid_o && iomem_ready_i) begin
            if (iomem_wstrb_o == '1) begin
               mem[mem_index(iomem_addr_o)] = iomem_wdata_o;
            end
            ready_next = 1'b0;
            wait_cnt = -1;
         end else if (iomem_valid_o) begin
            if (wait_cnt < 0) begin
               wait_cnt = int'($urandom_range(3, 0));
            end
            if (wait_cnt == 0) begin
               ready_next = 1'b1;
            end else begin
               ready_next = 1'b0;
               wait_cnt--;
            end
         end else begin
            ready_next = 1'b0;
            wait_cnt = -1;
         end
         @(negedge clk);
         iomem_ready_i = ready_next;
      end
   end

   // Starts and ends on a falling edge
   task automatic run_access(input entry_t e);
      logic accepted;
      logic ext;
      accepted = 1'b0;
      ext = is_external(e.addr);
      req_valid_i = 1'b1;
      req_addr_i = e.addr;
      req_wdata_i = e.wdata;
      req_write_i = e.write;
      while (!accepted) begin
         @(posedge clk);
         accepted = req_ready_o;
         if (ext) begin
            assert (iomem_valid_o)
               else report_failure("iomem_valid_o low during an external request");
            assert (req_ready_o == iomem_ready_i)
               else report_mismatch("req_ready_o", data_t'(req_ready_o),
                                    data_t'(iomem_ready_i));
            assert (iomem_addr_o == e.addr)
               else report_mismatch("iomem_addr_o", iomem_addr_o, e.addr);
            assert (iomem_wstrb_o == (e.write ? 4'hF : 4'h0))
               else report_mismatch("iomem_wstrb_o", data_t'(iomem_wstrb_o),
                                    e.write ? 32'hF : 32'h0);
            if (e.write) begin
               assert (iomem_wdata_o == e.wdata)
                  else report_mismatch("iomem_wdata_o", iomem_wdata_o, e.wdata);
            end
         end else begin
            assert (!iomem_valid_o)
               else report_failure("iomem_valid_o raised for a PWM or unmapped address");
            assert (accepted)
               else report_failure("PWM or unmapped request was not accepted at once");
         end
         @(negedge clk);
         if (!accepted) begin
            assert (!rsp_valid_o)
               else report_failure("rsp_valid_o high while a request was waiting");
         end
      end
      req_valid_i = 1'b0;
      if (e.write) begin
         assert (!rsp_valid_o) else report_failure("a write produced a response");
      end else begin
         assert (rsp_valid_o) else report_failure("no response in the cycle after a read");
         assert (rsp_data_o == e.exp_data)
            else report_mismatch("rsp_data_o", rsp_data_o, e.exp_data);
      end
   endtask

   task automatic count_pwm(input int cycles, output int cnt0, output int cnt1);
      cnt0 = 0;
      cnt1 = 0;
      repeat (cycles) begin
         @(negedge clk);
         cnt0 += int'(pwm0_o);
         cnt1 += int'(pwm1_o);
         assert (!rsp_valid_o) else report_failure("rsp_valid_o high with no request");
      end
   endtask

   initial begin : watchdog
      repeat (TIMEOUT_CYCLES) begin
         @(posedge clk);
      end
      report_failure("Timeout: the tests did not finish in the expected time");
   end

   initial begin : stimulus
      int   cnt0;
      int   cnt1;
      int   exp0;
      int   exp1;
      entry_t ctrl_ch0;
      resetn = 1'b0;
      req_valid_i = 1'b0;
      req_addr_i = '0;
      req_wdata_i = '0;
      req_write_i = 1'b0;
      repeat (RESET_CYCLES) begin
         @(negedge clk);
      end
      resetn = 1'b1;
      @(negedge clk);

      // Idle after reset
      assert (!rsp_valid_o) else report_mismatch("rsp_valid_o", rsp_valid_o, 0);
      assert (!iomem_valid_o) else report_mismatch("iomem_valid_o", iomem_valid_o, 0);
      assert (!pwm0_o) else report_mismatch("pwm0_o", pwm0_o, 0);
      assert (!pwm1_o) else report_mismatch("pwm1_o", pwm1_o, 0);

      for (int i = 0; i < NUM_ENTRIES; i++) begin
         run_access(stim_table[i]);
      end

      // Both channels running
      exp0 = 4 * min_int(PWM_D0, PWM_P + 1);
      exp1 = 4 * min_int(PWM_D1, PWM_P + 1);
      count_pwm(WINDOW / 2, cnt0, cnt1);
      count_pwm(WINDOW, cnt0, cnt1);
      assert (cnt0 == exp0) else report_mismatch("pwm0_o count", cnt0, exp0);
      assert (cnt1 == exp1) else report_mismatch("pwm1_o count", cnt1, exp1);
      count_pwm(3, cnt0, cnt1);
      count_pwm(WINDOW, cnt0, cnt1);
      assert (cnt0 == exp0) else report_mismatch("pwm0_o count", cnt0, exp0);
      assert (cnt1 == exp1) else report_mismatch("pwm1_o count", cnt1, exp1);

      // Channel 1 off
      ctrl_ch0 = '{1'b1, `SOC_PWM_BASE + `PWM_REG_CTRL, 32'h0000_0001, 32'h0};
      run_access(ctrl_ch0);
      count_pwm(WINDOW, cnt0, cnt1);
      assert (cnt0 == exp0) else report_mismatch("pwm0_o count", cnt0, exp0);
      assert (cnt1 == 0) else report_mismatch("pwm1_o count", cnt1, 0);

      $display("No errors");
      $finish;
   end

endmodule

// File: hdl/soc_periph_top.sv
module soc_periph_top (
   input  logic           clk,
   input  logic           resetn,

   // Bus master
   input  logic           req_valid_i,
   output logic           req_ready_o,
   input  soc_pkg::addr_t req_addr_i,
   input  soc_pkg::data_t req_wdata_i,
   input  logic           req_write_i,
   output logic           rsp_valid_o,
   output soc_pkg::data_t rsp_data_o,

   // External memory bus
   output logic           iomem_valid_o,
   input  logic           iomem_ready_i,
   output soc_pkg::strb_t iomem_wstrb_o,
   output soc_pkg::addr_t iomem_addr_o,
   output soc_pkg::data_t iomem_wdata_o,
   input  soc_pkg::data_t iomem_rdata_i,

   // PWM pins
   output logic           pwm0_o,
   output logic           pwm1_o
);

   periph_if pwm_bus ();

   bus_router u_router (
      .clk           (clk),
      .resetn        (resetn),
      .req_valid_i   (req_valid_i),
      .req_addr_i    (req_addr_i),
      .req_wdata_i   (req_wdata_i),
      .req_write_i   (req_write_i),
      .req_ready_o   (req_ready_o),
      .rsp_valid_o   (rsp_valid_o),
      .rsp_data_o    (rsp_data_o),
      .iomem_valid_o (iomem_valid_o),
      .iomem_ready_i (iomem_ready_i),
      .iomem_wstrb_o (iomem_wstrb_o),
      .iomem_addr_o  (iomem_addr_o),
      .iomem_wdata_o (iomem_wdata_o),
      .iomem_rdata_i (iomem_rdata_i),
      .pwm           (pwm_bus)
   );

   pwm_ctrl u_pwm (
      .clk    (clk),
      .resetn (resetn),
      .bus    (pwm_bus),
      .pwm0_o (pwm0_o),
      .pwm1_o (pwm1_o)
   );

endmodule

// File: hdl/pwm_ctrl.sv
`include "soc_cfg.svh"

module pwm_ctrl (
   input  logic     clk,
   input  logic     resetn,

   periph_if.dev_mp bus,

   output logic     pwm0_o,
   output logic     pwm1_o
);
   import soc_pkg::*;

   localparam int NUM_CH = 2;

   pwm_cnt_t          period_q;
   pwm_cnt_t          duty_q [NUM_CH];
   logic [NUM_CH-1:0] en_q;
   logic [NUM_CH-1:0] en_d;
   pwm_cnt_t          cnt_q;
   logic [NUM_CH-1:0] pwm_q;
   logic              wr_en;

   assign wr_en = bus.sel && bus.write;

   // Enable value in effect after this edge
   assign en_d = (wr_en && (bus.off == `PWM_REG_CTRL)) ? bus.wdata[NUM_CH-1:0] : en_q;

   // Register file
   always_ff @(posedge clk) begin
      if (!resetn) begin
         period_q <= '0;
         duty_q   <= '{default: '0};
         en_q     <= '0;
      end else begin
         if (wr_en) begin
            case (bus.off)
               `PWM_REG_PERIOD: begin
                  period_q <= bus.wdata[`PWM_CNT_W-1:0];
               end
               `PWM_REG_DUTY0: begin
                  duty_q[0] <= bus.wdata[`PWM_CNT_W-1:0];
               end
               `PWM_REG_DUTY1: begin
                  duty_q[1] <= bus.wdata[`PWM_CNT_W-1:0];
               end
               default: begin
               end
            endcase
         end
         en_q <= en_d;
      end
   end

   // Free-running period counter, wraps after reaching period
   always_ff @(posedge clk) begin
      if (!resetn) begin
         cnt_q <= '0;
      end else if (cnt_q >= period_q) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // Compare outputs
   always_ff @(posedge clk) begin
      if (!resetn) begin
         pwm_q <= '0;
      end else begin
         for (int ch = 0; ch < NUM_CH; ch++) begin
            pwm_q[ch] <= en_d[ch] && (cnt_q < duty_q[ch]);
         end
      end
   end

   assign pwm0_o = pwm_q[0];
   assign pwm1_o = pwm_q[1];

   // Readback, zero-extended
   always_comb begin
      case (bus.off)
         `PWM_REG_PERIOD: begin
            bus.rdata = data_t'(period_q);
         end
         `PWM_REG_DUTY0: begin
            bus.rdata = data_t'(duty_q[0]);
         end
         `PWM_REG_DUTY1: begin
            bus.rdata = data_t'(duty_q[1]);
         end
         `PWM_REG_CTRL: begin
            bus.rdata = data_t'(en_q);
         end
         default: begin
            bus.rdata = '0;
         end
      endcase
   end

   // Disabled channel never drives high, even across a control write
   assert property (@(posedge clk) disable iff (!resetn)
      (pwm_q & ~en_q) == '0)
      else $error("PWM output high with its channel disabled");

endmodule

// File: hdl/bus_router.sv
`include "soc_cfg.svh"

module bus_router (
   input  logic           clk,
   input  logic           resetn,

   input  logic           req_valid_i,
   input  soc_pkg::addr_t req_addr_i,
   input  soc_pkg::data_t req_wdata_i,
   input  logic           req_write_i,
   output logic           req_ready_o,

   output logic           rsp_valid_o,
   output soc_pkg::data_t rsp_data_o,

   output logic           iomem_valid_o,
   input  logic           iomem_ready_i,
   output soc_pkg::strb_t iomem_wstrb_o,
   output soc_pkg::addr_t iomem_addr_o,
   output soc_pkg::data_t iomem_wdata_o,
   input  soc_pkg::data_t iomem_rdata_i,

   periph_if.bus_mp       pwm
);
   import soc_pkg::*;

   region_e region;
   logic    ext_sel;
   logic    req_accept;
   logic    rd_accept;
   data_t   rd_data;
   logic    rsp_valid_q;
   data_t   rsp_data_q;

   // Address decode
   always_comb begin
      if ((req_addr_i & ~`SOC_RAM_MASK) == `SOC_RAM_BASE) begin
         region = REGION_RAM;
      end else if ((req_addr_i & ~`SOC_TIMER_MASK) == `SOC_TIMER_BASE) begin
         region = REGION_TIMER;
      end else if ((req_addr_i & ~`SOC_PWM_MASK) == `SOC_PWM_BASE) begin
         region = REGION_PWM;
      end else begin
         region = REGION_NONE;
      end
   end

   assign ext_sel = (region == REGION_RAM) || (region == REGION_TIMER);

   // External memory bus
   assign iomem_valid_o = req_valid_i && ext_sel;
   assign iomem_addr_o  = req_addr_i;
   assign iomem_wdata_o = req_wdata_i;
   assign iomem_wstrb_o = req_write_i ? '1 : '0;

   // On-chip PWM window
   assign pwm.sel   = req_valid_i && (region == REGION_PWM);
   assign pwm.off   = pwm_off_t'(req_addr_i & `SOC_PWM_MASK);
   assign pwm.wdata = req_wdata_i;
   assign pwm.write = req_write_i;

   // PWM and unmapped accesses finish in one cycle
   assign req_ready_o = ext_sel ? iomem_ready_i : 1'b1;

   assign req_accept = req_valid_i && req_ready_o;
   assign rd_accept  = req_accept && !req_write_i;

   // Read data source
   always_comb begin
      case (region)
         REGION_RAM, REGION_TIMER: begin
            rd_data = iomem_rdata_i;
         end
         REGION_PWM: begin
            rd_data = pwm.rdata;
         end
         default: begin
            rd_data = '0;
         end
      endcase
   end

   // Response one cycle after a read is accepted
   always_ff @(posedge clk) begin
      if (!resetn) begin
         rsp_valid_q <= 1'b0;
      end else begin
         rsp_valid_q <= rd_accept;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_accept) begin
         rsp_data_q <= rd_data;
      end
   end

   assign rsp_valid_o = rsp_valid_q;
   assign rsp_data_o  = rsp_data_q;

   // External bus only ever sees RAM or timer addresses
   assert property (@(posedge clk) disable iff (!resetn)
      iomem_valid_o |-> !pwm.sel &&
         (((iomem_addr_o & ~`SOC_RAM_MASK) == `SOC_RAM_BASE) ||
          ((iomem_addr_o & ~`SOC_TIMER_MASK) == `SOC_TIMER_BASE)))
      else $error("iomem_valid_o raised for a non-external address");

   // No response without an accepted read the cycle before
   assert property (@(posedge clk) disable iff (!resetn)
      rsp_valid_o |-> $past(req_valid_i && req_ready_o && !req_write_i))
      else $error("rsp_valid_o without an accepted read");

endmodule

// File: hdl/periph_if.sv
interface periph_if;
   import soc_pkg::*;

   // Access from the router
   logic     sel;
   pwm_off_t off;
   data_t    wdata;
   logic     write;

   // Register readback, combinational in the device
   data_t    rdata;

   modport bus_mp (
      output sel,
      output off,
      output wdata,
      output write,
      input  rdata
   );

   modport dev_mp (
      input  sel,
      input  off,
      input  wdata,
      input  write,
      output rdata
   );

endinterface

// File: hdl/soc_pkg.sv
`include "soc_cfg.svh"

package soc_pkg;

   // Bus fields
   typedef logic [`SOC_ADDR_W-1:0] addr_t;
   typedef logic [`SOC_DATA_W-1:0] data_t;
   typedef logic [`SOC_STRB_W-1:0] strb_t;

   // PWM period and duty values
   typedef logic [`PWM_CNT_W-1:0] pwm_cnt_t;

   // Register offset inside a peripheral window
   typedef logic [`PWM_OFF_W-1:0] pwm_off_t;

   // Destination of a request
   typedef enum logic [1:0] {
      REGION_RAM,
      REGION_TIMER,
      REGION_PWM,
      REGION_NONE
   } region_e;

endpackage

// File: hdl/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_STRB_W 4

// Address windows
// Mask covers the offset bits of each window
`define SOC_RAM_BASE   32'h4000_0000
`define SOC_RAM_MASK   32'h0000_FFFF

`define SOC_TIMER_BASE 32'h3000_0000
`define SOC_TIMER_MASK 32'h0000_000F

`define SOC_PWM_BASE   32'h2000_0000
`define SOC_PWM_MASK   32'h0000_00FF

// PWM block
`define PWM_CNT_W 16
`define PWM_OFF_W 8

// PWM register offsets
`define PWM_REG_PERIOD 8'h00
`define PWM_REG_DUTY0  8'h04
`define PWM_REG_DUTY1  8'h08
`define PWM_REG_CTRL   8'h0C

`endif
